//--- hw/cache_bank_config.svh
`ifndef CACHE_BANK_CONFIG_SVH
`define CACHE_BANK_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NUM_SETS   8
`define NUM_WAYS   4
`define BLOCK_SIZE 4

`define WORD_W     32
`define ADDR_W     16 // word address.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// derived widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SET_BITS   ($clog2(`NUM_SETS))
`define WAY_BITS   ($clog2(`NUM_WAYS))
`define OFF_BITS   ($clog2(`BLOCK_SIZE))
`define TAG_W      (`ADDR_W - `SET_BITS - `OFF_BITS)

`define AGE_W      (`WAY_BITS + 1) // one spare bit so ages can saturate.
`define AGE_MAX    ((1 << `AGE_W) - 1)

`endif

//--- hw/cache_bank_pkg.sv
`include "cache_bank_config.svh"

package cache_bank_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                                valid;
    logic                                dirty;
    logic [`TAG_W-1:0]                   tag;
    logic [`BLOCK_SIZE-1:0][`WORD_W-1:0] block;
  } cache_frame;

  typedef cache_frame [`NUM_WAYS-1:0] cache_set;

  typedef struct packed {
    logic [`NUM_WAYS-1:0][`AGE_W-1:0] age;
    logic [`WAY_BITS-1:0]             lru_way; // oldest way of the set.
  } lru_frame;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // requests and miss handling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } req_op_t;

  typedef struct packed {
    logic [`TAG_W-1:0]    tag;
    logic [`SET_BITS-1:0] set;
  } block_addr_t;

  typedef struct packed {
    req_op_t               op;
    block_addr_t           block_addr;
    logic [`OFF_BITS-1:0]  offset;
    logic [`WORD_W-1:0]    store_value;
  } mshr_reg;

  typedef enum logic [1:0] {
    IDLE,
    VICTIM_EJECT,
    BLOCK_PULL,
    FINISH
  } miss_state_t;

endpackage

//--- hw/cache_bank_ifs.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

// registered request plus tag compare result.
interface lookup_if;
  import cache_bank_pkg::*;

  logic                 valid;
  req_op_t              op;
  logic [`SET_BITS-1:0] set_index;
  logic [`OFF_BITS-1:0] offset;
  logic [`TAG_W-1:0]    tag;
  logic [`WORD_W-1:0]   wdata;
  logic                 hit;
  logic [`WAY_BITS-1:0] hit_way;

  modport stage (output valid, op, set_index, offset, tag, wdata, hit, hit_way);
  modport sink  (input  valid, op, set_index, offset, tag, wdata, hit, hit_way);
endinterface

interface lru_if;
  logic                 touch_en;
  logic [`SET_BITS-1:0] touch_set;
  logic [`WAY_BITS-1:0] touch_way;
  logic [`SET_BITS-1:0] query_set; // set whose victim is wanted.
  logic [`WAY_BITS-1:0] victim_way;

  modport tracker   (input touch_en, touch_set, touch_way, query_set, output victim_way);
  modport requester (output query_set, input victim_way);
  modport toucher   (output touch_en, touch_set, touch_way);
endinterface

interface fill_if;
  logic [`SET_BITS-1:0]                eject_set;
  logic [`WAY_BITS-1:0]                eject_way;
  logic [`OFF_BITS-1:0]                eject_off;
  logic [`WORD_W-1:0]                  eject_word;
  logic                                fill_en;
  logic [`SET_BITS-1:0]                fill_set;
  logic [`WAY_BITS-1:0]                fill_way;
  logic [`TAG_W-1:0]                   fill_tag;
  logic [`BLOCK_SIZE-1:0][`WORD_W-1:0] fill_block;
  logic                                victim_valid;
  logic                                victim_dirty;
  logic [`TAG_W-1:0]                   victim_tag;

  modport master (output eject_set, eject_way, eject_off, fill_en, fill_set, fill_way,
                  fill_tag, fill_block,
                  input  eject_word, victim_valid, victim_dirty, victim_tag);
  modport array  (input  eject_set, eject_way, eject_off, fill_en, fill_set, fill_way,
                  fill_tag, fill_block,
                  output eject_word, victim_valid, victim_dirty, victim_tag);
endinterface

//--- hw/tag_lookup.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module tag_lookup (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     req_valid,
  input  cache_bank_pkg::req_op_t  req_op,
  input  logic [`ADDR_W-1:0]       req_addr,
  input  logic [`WORD_W-1:0]       req_wdata,
  input  cache_bank_pkg::cache_set frames,
  input  logic                     replay,
  input  cache_bank_pkg::mshr_reg  mshr,
  lookup_if.stage                  lk
);
  import cache_bank_pkg::*;

  logic               valid_q;
  req_op_t            op_q;
  logic [`ADDR_W-1:0] addr_q;
  logic [`WORD_W-1:0] wdata_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid || replay;
    end
  end

  // replay wins because the bank is busy and no new request can collide.
  always_ff @(posedge CLK) begin
    if (replay) begin
      op_q    <= mshr.op;
      addr_q  <= {mshr.block_addr.tag, mshr.block_addr.set, mshr.offset};
      wdata_q <= mshr.store_value;
    end else if (req_valid) begin
      op_q    <= req_op;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  assign lk.valid     = valid_q;
  assign lk.op        = op_q;
  assign lk.wdata     = wdata_q;
  assign lk.offset    = addr_q[`OFF_BITS-1:0];
  assign lk.set_index = addr_q[`OFF_BITS +: `SET_BITS];
  assign lk.tag       = addr_q[`ADDR_W-1 -: `TAG_W];

  // compare against every way of the indexed set.
  always_comb begin
    lk.hit     = 1'b0;
    lk.hit_way = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (frames[w].valid && (frames[w].tag == lk.tag)) begin
        lk.hit     = 1'b1;
        lk.hit_way = w[`WAY_BITS-1:0];
      end
    end
  end

endmodule

//--- hw/lru_tracker.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module lru_tracker (
  input  logic   CLK,
  input  logic   nRST,
  lru_if.tracker lr
);
  import cache_bank_pkg::*;

  lru_frame [`NUM_SETS-1:0] lru;
  lru_frame                 next_frame;
  logic [`AGE_W-1:0]        touched_age;

  // oldest way with the lowest index winning a tie so empty ways fill in order.
  function automatic logic [`WAY_BITS-1:0] oldest(
    input logic [`NUM_WAYS-1:0][`AGE_W-1:0] age
  );
    logic [`WAY_BITS-1:0] sel;
    sel = '0;
    for (int w = 1; w < `NUM_WAYS; w++) begin
      if (age[w] > age[sel]) begin
        sel = w[`WAY_BITS-1:0];
      end
    end
    return sel;
  endfunction

  always_comb begin
    next_frame  = lru[lr.touch_set];
    touched_age = next_frame.age[lr.touch_way];
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (w[`WAY_BITS-1:0] == lr.touch_way) begin
        next_frame.age[w] = '0;
      end else if ((next_frame.age[w] <= touched_age) && (next_frame.age[w] != `AGE_MAX)) begin
        next_frame.age[w] = next_frame.age[w] + 1'b1; // ages younger or equal move up.
      end
    end
    next_frame.lru_way = oldest(next_frame.age);
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      lru <= '0;
    end else if (lr.touch_en) begin
      lru[lr.touch_set] <= next_frame;
    end
  end

  assign lr.victim_way = lru[lr.query_set].lru_way;

endmodule

//--- hw/miss_handler.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module miss_handler (
  input  logic                    CLK,
  input  logic                    nRST,
  lookup_if.sink                  lk,
  lru_if.requester                lr,
  fill_if.master                  fl,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic [`ADDR_W-1:0]      mem_addr,
  output logic [`WORD_W-1:0]      mem_wdata,
  input  logic [`WORD_W-1:0]      mem_rdata,
  input  logic                    mem_ready,
  output logic                    busy,
  output logic                    replay,
  output cache_bank_pkg::mshr_reg mshr
);
  import cache_bank_pkg::*;

  miss_state_t                         state;
  logic [`OFF_BITS-1:0]                count;
  logic [`SET_BITS-1:0]                victim_set;
  logic [`WAY_BITS-1:0]                victim_way;
  logic [`TAG_W-1:0]                   victim_tag;
  logic [`BLOCK_SIZE-1:0][`WORD_W-1:0] pull_buf;
  logic                                replay_q;
  logic                                miss;
  logic                                last_word;

  assign miss      = (state == IDLE) && lk.valid && !lk.hit;
  assign last_word = mem_ready && (count == `OFF_BITS'(`BLOCK_SIZE - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // victim selection and eject read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign lr.query_set = lk.set_index;
  assign fl.eject_set = (state == IDLE) ? lk.set_index : victim_set; // peek before latching.
  assign fl.eject_way = (state == IDLE) ? lr.victim_way : victim_way;
  assign fl.eject_off = count;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // miss FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      count    <= '0;
      replay_q <= 1'b0;
    end else begin
      replay_q <= (state == FINISH);
      case (state)
        IDLE: begin
          if (miss) begin
            count <= '0;
            state <= (fl.victim_valid && fl.victim_dirty) ? VICTIM_EJECT : BLOCK_PULL;
          end
        end
        VICTIM_EJECT: begin
          if (mem_ready) begin
            count <= count + 1'b1; // wraps to zero on the last word.
            if (last_word) begin
              state <= BLOCK_PULL;
            end
          end
        end
        BLOCK_PULL: begin
          if (mem_ready) begin
            count <= count + 1'b1;
            if (last_word) begin
              state <= FINISH;
            end
          end
        end
        FINISH: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (miss) begin
      mshr.op             <= lk.op;
      mshr.block_addr.tag <= lk.tag;
      mshr.block_addr.set <= lk.set_index;
      mshr.offset         <= lk.offset;
      mshr.store_value    <= lk.wdata;
      victim_set          <= lk.set_index;
      victim_way          <= lr.victim_way;
      victim_tag          <= fl.victim_tag;
    end
    if ((state == BLOCK_PULL) && mem_ready) begin
      pull_buf[count] <= mem_rdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory side, fill and replay
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign mem_write = (state == VICTIM_EJECT);
  assign mem_read  = (state == BLOCK_PULL);
  assign mem_addr  = (state == VICTIM_EJECT) ? {victim_tag, victim_set, count}
                                             : {mshr.block_addr.tag, mshr.block_addr.set, count};
  assign mem_wdata = fl.eject_word;

  assign fl.fill_en    = (state == FINISH);
  assign fl.fill_set   = victim_set;
  assign fl.fill_way   = victim_way;
  assign fl.fill_tag   = mshr.block_addr.tag;
  assign fl.fill_block = pull_buf;

  assign replay = (state == FINISH);
  assign busy   = (state != IDLE) || miss || replay_q; // held through the replayed lookup.

endmodule

//--- hw/bank_array.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module bank_array (
  input  logic                     CLK,
  input  logic                     nRST,
  lookup_if.sink                   lk,
  fill_if.array                    fl,
  lru_if.toucher                   lr,
  output cache_bank_pkg::cache_set frames,
  output logic                     resp_valid,
  output logic [`WORD_W-1:0]       resp_rdata
);
  import cache_bank_pkg::*;

  cache_set [`NUM_SETS-1:0] bank;
  cache_frame               victim;
  logic                     hit;
  logic                     store_hit;

  assign hit       = lk.valid && lk.hit;
  assign store_hit = hit && (lk.op == OP_STORE);

  assign frames = bank[lk.set_index];

  // victim probe and eject words.
  assign victim          = bank[fl.eject_set][fl.eject_way];
  assign fl.victim_valid = victim.valid;
  assign fl.victim_dirty = victim.dirty;
  assign fl.victim_tag   = victim.tag;
  assign fl.eject_word   = victim.block[fl.eject_off];

  // hit and fill never share a cycle.
  assign lr.touch_en  = hit || fl.fill_en;
  assign lr.touch_set = fl.fill_en ? fl.fill_set : lk.set_index;
  assign lr.touch_way = fl.fill_en ? fl.fill_way : lk.hit_way;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      bank       <= '0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= hit;
      if (fl.fill_en) begin
        bank[fl.fill_set][fl.fill_way].valid <= 1'b1;
        bank[fl.fill_set][fl.fill_way].dirty <= 1'b0;
        bank[fl.fill_set][fl.fill_way].tag   <= fl.fill_tag;
        bank[fl.fill_set][fl.fill_way].block <= fl.fill_block;
      end
      if (store_hit) begin
        bank[lk.set_index][lk.hit_way].block[lk.offset] <= lk.wdata;
        bank[lk.set_index][lk.hit_way].dirty            <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (hit) begin
      resp_rdata <= store_hit ? lk.wdata : frames[lk.hit_way].block[lk.offset];
    end
  end

endmodule

//--- hw/cache_bank_top.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module cache_bank_top (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    req_valid,
  input  cache_bank_pkg::req_op_t req_op,
  input  logic [`ADDR_W-1:0]      req_addr,
  input  logic [`WORD_W-1:0]      req_wdata,
  output logic                    resp_valid,
  output logic [`WORD_W-1:0]      resp_rdata,
  output logic                    busy,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic [`ADDR_W-1:0]      mem_addr,
  output logic [`WORD_W-1:0]      mem_wdata,
  input  logic [`WORD_W-1:0]      mem_rdata,
  input  logic                    mem_ready
);
  import cache_bank_pkg::*;

  cache_set frames;
  mshr_reg  mshr;
  logic     replay;

  lookup_if lk_bus ();
  lru_if    lru_bus ();
  fill_if   fill_bus ();

  tag_lookup u_lookup (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .frames    (frames),
    .replay    (replay),
    .mshr      (mshr),
    .lk        (lk_bus)
  );

  lru_tracker u_lru (
    .CLK  (CLK),
    .nRST (nRST),
    .lr   (lru_bus)
  );

  miss_handler u_miss (
    .CLK       (CLK),
    .nRST      (nRST),
    .lk        (lk_bus),
    .lr        (lru_bus),
    .fl        (fill_bus),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .busy      (busy),
    .replay    (replay),
    .mshr      (mshr)
  );

  bank_array u_array (
    .CLK        (CLK),
    .nRST       (nRST),
    .lk         (lk_bus),
    .fl         (fill_bus),
    .lr         (lru_bus),
    .frames     (frames),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata)
  );

endmodule

//--- verif/cache_bank_assertions.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module cache_bank_assertions (
  input logic                                CLK,
  input logic                                nRST,
  input cache_bank_pkg::lru_frame [`NUM_SETS-1:0] lru,
  input cache_bank_pkg::cache_set [`NUM_SETS-1:0] bank,
  input cache_bank_pkg::miss_state_t         state,
  input logic                                touch_en,
  input logic [`SET_BITS-1:0]                touch_set,
  input logic [`WAY_BITS-1:0]                touch_way,
  input logic                                fill_en,
  input logic [`SET_BITS-1:0]                fill_set,
  input logic [`WAY_BITS-1:0]                fill_way,
  input logic [`TAG_W-1:0]                   fill_tag,
  input logic [`BLOCK_SIZE-1:0][`WORD_W-1:0] fill_block,
  input logic                                store_hit,
  input logic [`SET_BITS-1:0]                set_index,
  input logic [`WAY_BITS-1:0]                hit_way,
  input logic [`OFF_BITS-1:0]                offset,
  input logic [`WORD_W-1:0]                  wdata
);
  import cache_bank_pkg::*;

  logic [`SET_BITS-1:0]                tset_q;
  logic [`WAY_BITS-1:0]                tway_q;
  logic [`SET_BITS-1:0]                fset_q;
  logic [`WAY_BITS-1:0]                fway_q;
  logic [`TAG_W-1:0]                   ftag_q;
  logic [`BLOCK_SIZE-1:0][`WORD_W-1:0] fblk_q;
  logic [`SET_BITS-1:0]                sset_q;
  logic [`WAY_BITS-1:0]                sway_q;
  logic [`OFF_BITS-1:0]                soff_q;
  logic [`WORD_W-1:0]                  swdata_q;
  int                                  fail_count = 0;

  // a touched way must end up as the only way of its set at age zero.
  function automatic logic youngest_only(input lru_frame f, input logic [`WAY_BITS-1:0] way);
    logic ok;
    ok = (f.age[way] == '0);
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if ((w[`WAY_BITS-1:0] != way) && (f.age[w] == '0)) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  always_ff @(posedge CLK) begin
    tset_q   <= touch_set;
    tway_q   <= touch_way;
    fset_q   <= fill_set;
    fway_q   <= fill_way;
    ftag_q   <= fill_tag;
    fblk_q   <= fill_block;
    sset_q   <= set_index;
    sway_q   <= hit_way;
    soff_q   <= offset;
    swdata_q <= wdata;
  end

  a_lru_order: assert property (@(posedge CLK) disable iff (!nRST)
    touch_en |=> youngest_only(lru[tset_q], tway_q))
    else begin
      fail_count++;
      $error("touched way is not the only youngest way of its set");
    end

  a_age_reset: assert property (@(posedge CLK) disable iff (!nRST)
    (state == FINISH) |=> (lru[fset_q].age[fway_q] == '0))
    else begin
      fail_count++;
      $error("victim age not reset after FINISH");
    end

  a_block_fill: assert property (@(posedge CLK) disable iff (!nRST)
    fill_en |=> (bank[fset_q][fway_q].valid && !bank[fset_q][fway_q].dirty &&
                 (bank[fset_q][fway_q].tag == ftag_q) &&
                 (bank[fset_q][fway_q].block == fblk_q)))
    else begin
      fail_count++;
      $error("pulled block not installed in the victim way");
    end

  a_store_word: assert property (@(posedge CLK) disable iff (!nRST)
    store_hit |=> ((bank[sset_q][sway_q].block[soff_q] == swdata_q) &&
                   bank[sset_q][sway_q].dirty))
    else begin
      fail_count++;
      $error("store hit did not replace the word");
    end

endmodule

bind cache_bank_top cache_bank_assertions u_checks (
  .CLK        (CLK),
  .nRST       (nRST),
  .lru        (u_lru.lru),
  .bank       (u_array.bank),
  .state      (u_miss.state),
  .touch_en   (lru_bus.touch_en),
  .touch_set  (lru_bus.touch_set),
  .touch_way  (lru_bus.touch_way),
  .fill_en    (fill_bus.fill_en),
  .fill_set   (fill_bus.fill_set),
  .fill_way   (fill_bus.fill_way),
  .fill_tag   (fill_bus.fill_tag),
  .fill_block (fill_bus.fill_block),
  .store_hit  (u_array.store_hit),
  .set_index  (lk_bus.set_index),
  .hit_way    (lk_bus.hit_way),
  .offset     (lk_bus.offset),
  .wdata      (lk_bus.wdata)
);

//--- verif/cache_bank_tb.sv
`timescale 1ns/1ps
`include "cache_bank_config.svh"

module cache_bank_tb;
  import cache_bank_pkg::*;

  localparam int NUM_RAND    = 300;
  localparam int NUM_REQ     = NUM_RAND + 20;
  localparam int MISS_MAX    = 2 * `BLOCK_SIZE * 4 + 10; // eject plus pull with stalls.
  localparam int CYCLE_LIMIT = NUM_REQ * MISS_MAX + 100;

  logic               CLK;
  logic               nRST;
  logic               req_valid;
  req_op_t            req_op;
  logic [`ADDR_W-1:0] req_addr;
  logic [`WORD_W-1:0] req_wdata;
  logic               resp_valid;
  logic [`WORD_W-1:0] resp_rdata;
  logic               busy;
  logic               mem_read;
  logic               mem_write;
  logic [`ADDR_W-1:0] mem_addr;
  logic [`WORD_W-1:0] mem_wdata;
  logic [`WORD_W-1:0] mem_rdata;
  logic               mem_ready = 1'b0;

  logic [`WORD_W-1:0] mem    [0:(1<<`ADDR_W)-1];
  logic [`WORD_W-1:0] shadow [0:(1<<`ADDR_W)-1]; // latest value of every address.

  req_op_t            rand_op   [NUM_RAND];
  logic [`ADDR_W-1:0] rand_addr [NUM_RAND];
  logic [`WORD_W-1:0] rand_data [NUM_RAND];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference cache state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic              ref_valid [`NUM_SETS][`NUM_WAYS];
  logic              ref_dirty [`NUM_SETS][`NUM_WAYS];
  logic [`TAG_W-1:0] ref_tag   [`NUM_SETS][`NUM_WAYS];
  int                ref_age   [`NUM_SETS][`NUM_WAYS];

  logic               exp_wb;
  logic [`ADDR_W-1:0] exp_wb_base;
  logic [`ADDR_W-1:0] exp_rd_addr;
  logic [`WORD_W-1:0] exp_rdata;
  int                 wb_words;
  int                 rd_words;
  int                 errors = 0;
  int                 cycles = 0;
  integer             seed   = 32'hd35a09dd;

  cache_bank_top dut (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [`WORD_W-1:0] fill_word(input int a);
    return (32'(a) * 32'h9e3779b1) ^ 32'h0f0f1234;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic int oldest_way(input logic [`SET_BITS-1:0] s);
    int sel;
    sel = 0;
    for (int w = 1; w < `NUM_WAYS; w++) begin
      if (ref_age[s][w] > ref_age[s][sel]) sel = w;
    end
    return sel;
  endfunction

  function automatic void touch_way(input logic [`SET_BITS-1:0] s, input int w);
    int t;
    t = ref_age[s][w];
    for (int i = 0; i < `NUM_WAYS; i++) begin
      if (i == w) ref_age[s][i] = 0;
      else if ((ref_age[s][i] <= t) && (ref_age[s][i] != `AGE_MAX)) ref_age[s][i]++;
    end
  endfunction

  // updates the model and returns whether the access hits.
  function automatic logic model_access(input req_op_t op, input logic [`ADDR_W-1:0] a,
                                        input logic [`WORD_W-1:0] d);
    logic [`SET_BITS-1:0] s;
    logic [`TAG_W-1:0]    t;
    logic                 hit;
    int                   w;
    s   = a[`OFF_BITS +: `SET_BITS];
    t   = a[`ADDR_W-1 -: `TAG_W];
    hit = 1'b0;
    w   = 0;
    for (int i = 0; i < `NUM_WAYS; i++) begin
      if (ref_valid[s][i] && (ref_tag[s][i] == t)) begin
        hit = 1'b1;
        w   = i;
      end
    end
    exp_wb = 1'b0;
    if (!hit) begin
      w = oldest_way(s);
      if (ref_valid[s][w] && ref_dirty[s][w]) begin
        exp_wb      = 1'b1;
        exp_wb_base = {ref_tag[s][w], s, {`OFF_BITS{1'b0}}};
      end
      ref_valid[s][w] = 1'b1;
      ref_dirty[s][w] = 1'b0;
      ref_tag[s][w]   = t;
      touch_way(s, w); // install and let the replayed hit touch again.
    end
    touch_way(s, w);
    if (op == OP_STORE) begin
      shadow[a]       = d;
      ref_dirty[s][w] = 1'b1;
      exp_rdata       = d;
    end else begin
      exp_rdata = shadow[a];
    end
    return hit;
  endfunction

  task automatic do_request(input req_op_t op, input logic [`ADDR_W-1:0] a,
                            input logic [`WORD_W-1:0] d);
    logic exp_hit;
    int   lat;
    @(posedge CLK);
    exp_hit     = model_access(op, a, d);
    exp_rd_addr = a;
    wb_words    = 0;
    rd_words    = 0;
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= a;
    req_wdata <= d;
    @(posedge CLK);
    req_valid <= 1'b0;
    lat = 0;
    do begin
      @(posedge CLK);
      lat++;
      if (!resp_valid) check("busy", 32'(busy), 32'(!exp_hit));
    end while (!resp_valid);
    if (exp_hit) check("resp latency", lat, 2);
    check("write-back words", wb_words, exp_wb ? `BLOCK_SIZE : 0);
    check("pulled words", rd_words, exp_hit ? 0 : `BLOCK_SIZE);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory model and compare processes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign mem_rdata = mem[mem_addr];

  always @(posedge CLK) begin
    if (mem_write && mem_ready) mem[mem_addr] <= mem_wdata;
    mem_ready <= nRST && (($random(seed) & 3) != 0); // ready three cycles in four.
  end

  always @(posedge CLK) begin
    if (resp_valid) check("resp_rdata", resp_rdata, exp_rdata);
    if (nRST && mem_write && mem_ready) begin
      check("mem_write", 32'(mem_write), 32'(exp_wb));
      check("mem_addr block", 32'(mem_addr >> `OFF_BITS), 32'(exp_wb_base >> `OFF_BITS));
      check("mem_wdata", mem_wdata, shadow[mem_addr]);
      wb_words++;
    end
    if (nRST && mem_read && mem_ready) begin
      check("mem_read addr block", 32'(mem_addr >> `OFF_BITS), 32'(exp_rd_addr >> `OFF_BITS));
      rd_words++;
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [31:0] r;
    nRST      = 1'b0;
    req_valid = 1'b0;
    req_op    = OP_LOAD;
    req_addr  = '0;
    req_wdata = '0;
    for (int a = 0; a < (1 << `ADDR_W); a++) begin
      mem[a]    = fill_word(a);
      shadow[a] = fill_word(a);
    end
    for (int s = 0; s < `NUM_SETS; s++) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
        ref_age[s][w]   = 0;
      end
    end
    for (int n = 0; n < NUM_RAND; n++) begin
      r            = $random(seed);
      rand_op[n]   = req_op_t'(r[12]);
      rand_addr[n] = {8'd0, r[10:8], 2'b00, r[0], r[5:4]};
      rand_data[n] = $random(seed);
    end
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    check("resp_valid", 32'(resp_valid), 0);
    check("busy", 32'(busy), 0);
    check("mem_read", 32'(mem_read), 0);
    check("mem_write", 32'(mem_write), 0);

    do_request(OP_STORE, 16'h0124, 32'hcafe0001); // cold miss.
    do_request(OP_LOAD, 16'h0124, '0);            // hit on the stored word.
    do_request(OP_LOAD, 16'h0a31, '0);            // cold load from memory.
    for (int i = 0; i < `NUM_WAYS + 1; i++) begin
      do_request(OP_STORE, {11'(i + 1), 3'd3, 2'd1}, 32'h1000 + i); // last one evicts dirty.
    end
    do_request(OP_LOAD, {11'd1, 3'd3, 2'd1}, '0); // reload the written-back block.
    for (int i = 0; i < `NUM_WAYS + 2; i++) begin
      do_request(OP_LOAD, {11'(i + 1), 3'd5, 2'd2}, '0); // clean victims.
    end

    for (int n = 0; n < NUM_RAND; n++) begin
      do_request(rand_op[n], rand_addr[n], rand_data[n]);
    end

    repeat (3) @(posedge CLK);
    errors += dut.u_checks.fail_count;
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- cache_bank.f
+incdir+hw
hw/cache_bank_pkg.sv
hw/cache_bank_ifs.sv
hw/tag_lookup.sv
hw/lru_tracker.sv
hw/miss_handler.sv
hw/bank_array.sv
hw/cache_bank_top.sv
verif/cache_bank_assertions.sv
verif/cache_bank_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_bank_tb
FLIST     ?= cache_bank.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
